// File: pet_pkg.sv
package pet_pkg;

    // Pet states, the code doubles as the display value
    typedef enum logic [3:0] {
        IDLE         = 4'd0,
        HUNGRY       = 4'd1,
        MALNOURISHED = 4'd2,
        EATING       = 4'd3,
        COUGH        = 4'd4,
        FEVER        = 4'd5,
        PILL         = 4'd6,
        TIRED        = 4'd7,
        SLEEPLESS    = 4'd8,
        SLEEPING     = 4'd9,
        SAD          = 4'd10,
        DEPRESSED    = 4'd11,
        CHEERED      = 4'd12
    } pet_state_t;

    typedef logic [1:0] level_t;

    localparam level_t LEVEL_FULL  = 2'd3;
    localparam level_t LEVEL_EMPTY = 2'd0;

    typedef logic [4:0] step_t;

    localparam step_t STEP_MAX = 5'd16;   // Wraps to 0 after this

    localparam int DIGIT_W  = 4;
    localparam int STATUS_W = 28;

    // Seven hex digits, food in the lowest
    typedef struct packed {
        logic [2*DIGIT_W-1:0] step;       // Digits 6 and 5
        logic [DIGIT_W-1:0]   display;
        logic [DIGIT_W-1:0]   rest;
        logic [DIGIT_W-1:0]   health;
        logic [DIGIT_W-1:0]   mood;
        logic [DIGIT_W-1:0]   food;
    } status_t;

endpackage

// File: pet_needs_if.sv
`timescale 1ns/100ps

interface pet_needs_if import pet_pkg::*; ();

    level_t level_food;
    level_t level_health;
    level_t level_rest;
    level_t level_mood;

    logic care_food;
    logic care_medicine;
    logic care_light;      // Light sensor
    logic care_presence;   // Ultrasonic sensor

    modport fsm (
        input level_food, level_health, level_rest, level_mood,
        input care_food, care_medicine, care_light, care_presence
    );

    modport status (
        input level_food, level_health, level_rest, level_mood
    );

endinterface

// File: test_stepper.sv
`timescale 1ns/100ps

module test_stepper import pet_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  test_mode,
    input  logic  test_step,
    output step_t step_count,
    output logic  test_exit
);

    logic mode_q;
    logic step_q;
    logic step_fall;

    // Falling edges against the previous sample
    assign step_fall = step_q & ~test_step;
    assign test_exit = mode_q & ~test_mode;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mode_q <= 1'b0;
            step_q <= 1'b0;
        end else begin
            mode_q <= test_mode;
            step_q <= test_step;
        end
    end

    // Step counter, frozen outside test mode
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_count <= '0;
        end else if (test_mode && step_fall) begin
            if (step_count == STEP_MAX) begin
                step_count <= '0;
            end else begin
                step_count <= step_count + 5'd1;
            end
        end
    end

endmodule

// File: pet_fsm.sv
`timescale 1ns/100ps

module pet_fsm import pet_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    pet_needs_if.fsm      needs,
    input  logic          test_mode,
    input  step_t         step_count,
    input  logic          test_exit,
    output pet_state_t    next_state
);

    pet_state_t state;
    pet_state_t normal_next;

    // One need's mild, severe and care states
    function automatic pet_state_t chain_next(
        input pet_state_t cur,
        input pet_state_t mild,
        input pet_state_t severe,
        input pet_state_t care_st,
        input level_t     level,
        input logic       care_in
    );
        chain_next = cur;
        if (cur == mild) begin
            if (level == LEVEL_EMPTY) begin
                chain_next = severe;
            end else if (care_in) begin
                chain_next = care_st;
            end
        end else if (cur == severe) begin
            if (care_in) begin
                chain_next = care_st;
            end
        end else if (cur == care_st) begin
            if (level == LEVEL_FULL && !care_in) begin
                chain_next = IDLE;
            end else if (care_in) begin
                chain_next = care_st;   // Care still going on
            end else if (level > LEVEL_EMPTY) begin
                chain_next = mild;
            end else begin
                chain_next = severe;
            end
        end
    endfunction

    // Test sequence, count 0 holds the state
    function automatic pet_state_t forced_state(
        input step_t      step,
        input pet_state_t cur
    );
        case (step)
            5'd1:    forced_state = HUNGRY;
            5'd2:    forced_state = MALNOURISHED;
            5'd3:    forced_state = EATING;
            5'd4:    forced_state = IDLE;
            5'd5:    forced_state = COUGH;
            5'd6:    forced_state = FEVER;
            5'd7:    forced_state = PILL;
            5'd8:    forced_state = IDLE;
            5'd9:    forced_state = TIRED;
            5'd10:   forced_state = SLEEPLESS;
            5'd11:   forced_state = SLEEPING;
            5'd12:   forced_state = IDLE;
            5'd13:   forced_state = SAD;
            5'd14:   forced_state = DEPRESSED;
            5'd15:   forced_state = CHEERED;
            5'd16:   forced_state = IDLE;
            default: forced_state = cur;
        endcase
    endfunction

    always_comb begin
        normal_next = state;
        case (state)
            IDLE: begin
                // Priority food, health, rest, mood
                if (needs.level_food < LEVEL_FULL) begin
                    normal_next = HUNGRY;
                end else if (needs.level_health < LEVEL_FULL) begin
                    normal_next = COUGH;
                end else if (needs.level_rest < LEVEL_FULL) begin
                    normal_next = TIRED;
                end else if (needs.level_mood < LEVEL_FULL) begin
                    normal_next = SAD;
                end
            end
            HUNGRY, MALNOURISHED, EATING: begin
                normal_next = chain_next(state, HUNGRY, MALNOURISHED, EATING,
                                         needs.level_food, needs.care_food);
            end
            COUGH, FEVER, PILL: begin
                normal_next = chain_next(state, COUGH, FEVER, PILL,
                                         needs.level_health, needs.care_medicine);
            end
            TIRED, SLEEPLESS, SLEEPING: begin
                normal_next = chain_next(state, TIRED, SLEEPLESS, SLEEPING,
                                         needs.level_rest, needs.care_light);
            end
            SAD, DEPRESSED, CHEERED: begin
                normal_next = chain_next(state, SAD, DEPRESSED, CHEERED,
                                         needs.level_mood, needs.care_presence);
            end
            default: normal_next = IDLE;
        endcase
    end

    assign next_state = test_mode ? forced_state(step_count, state) : normal_next;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
        end else if (test_exit) begin
            state <= IDLE;   // Leaving test mode
        end else begin
            state <= next_state;
        end
    end

endmodule

// File: pet_outputs.sv
`timescale 1ns/100ps

module pet_outputs import pet_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    pet_needs_if.status         needs,
    input  logic                test_mode,
    input  step_t               step_count,
    input  pet_state_t          next_state,
    output logic [3:0]          display,
    output logic                enable_food,
    output logic                enable_medicine,
    output logic                enable_light,
    output logic                enable_presence,
    output logic [STATUS_W-1:0] status
);

    logic    care_off;
    status_t status_next;

    // Sensors and buttons are locked out during care and in test mode
    assign care_off = test_mode || (next_state inside {EATING, PILL, SLEEPING, CHEERED});

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            display         <= 4'd0;
            enable_food     <= 1'b1;
            enable_medicine <= 1'b1;
            enable_light    <= 1'b1;
            enable_presence <= 1'b1;
        end else begin
            display         <= next_state;
            enable_food     <= !care_off;
            enable_medicine <= !care_off;
            enable_light    <= !care_off;
            enable_presence <= !care_off;
        end
    end

    always_comb begin
        status_next.step    = (2*DIGIT_W)'(step_count);
        status_next.display = display;          // Current display, not next_state
        status_next.rest    = DIGIT_W'(needs.level_rest);
        status_next.health  = DIGIT_W'(needs.level_health);
        status_next.mood    = DIGIT_W'(needs.level_mood);
        status_next.food    = DIGIT_W'(needs.level_food);
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            status <= '0;
        end else begin
            status <= status_next;
        end
    end

endmodule

// File: pet_top.sv
`timescale 1ns/100ps

module pet_top import pet_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  level_t              level_food,
    input  level_t              level_health,
    input  level_t              level_rest,
    input  level_t              level_mood,
    input  logic                care_food,
    input  logic                care_medicine,
    input  logic                care_light,
    input  logic                care_presence,
    input  logic                test_mode,
    input  logic                test_step,
    output logic [3:0]          display,
    output logic                enable_food,
    output logic                enable_medicine,
    output logic                enable_light,
    output logic                enable_presence,
    output logic [STATUS_W-1:0] status
);

    step_t      step_count;
    logic       test_exit;
    pet_state_t next_state;

    pet_needs_if needs ();

    assign needs.level_food    = level_food;
    assign needs.level_health  = level_health;
    assign needs.level_rest    = level_rest;
    assign needs.level_mood    = level_mood;
    assign needs.care_food     = care_food;
    assign needs.care_medicine = care_medicine;
    assign needs.care_light    = care_light;
    assign needs.care_presence = care_presence;

    test_stepper u_stepper (
        .clk        (clk),
        .reset      (reset),
        .test_mode  (test_mode),
        .test_step  (test_step),
        .step_count (step_count),
        .test_exit  (test_exit)
    );

    pet_fsm u_fsm (
        .clk        (clk),
        .reset      (reset),
        .needs      (needs.fsm),
        .test_mode  (test_mode),
        .step_count (step_count),
        .test_exit  (test_exit),
        .next_state (next_state)
    );

    pet_outputs u_outputs (
        .clk             (clk),
        .reset           (reset),
        .needs           (needs.status),
        .test_mode       (test_mode),
        .step_count      (step_count),
        .next_state      (next_state),
        .display         (display),
        .enable_food     (enable_food),
        .enable_medicine (enable_medicine),
        .enable_light    (enable_light),
        .enable_presence (enable_presence),
        .status          (status)
    );

endmodule

// File: pet_checker.sv
`timescale 1ns/100ps

module pet_checker import pet_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic       test_mode,
    input logic [3:0] display,
    input logic       enable_food,
    input logic       enable_medicine,
    input logic       enable_light,
    input logic       enable_presence,
    input step_t      step_count
);

    int fail_count = 0;

    // Registered enables follow test_mode one edge later
    property enables_off_in_test;
        @(posedge clk) disable iff (!reset)
            test_mode |=> !(enable_food || enable_medicine || enable_light || enable_presence);
    endproperty

    property display_in_range;
        @(posedge clk) disable iff (!reset) display <= 4'(CHEERED);
    endproperty

    property step_in_range;
        @(posedge clk) disable iff (!reset) step_count <= STEP_MAX;
    endproperty

    a_enables_off: assert property (enables_off_in_test)
        else begin
            fail_count++;
            $error("care enables high while in test mode");
        end
    a_display:     assert property (display_in_range)
        else begin
            fail_count++;
            $error("display code above CHEERED");
        end
    a_step:        assert property (step_in_range)
        else begin
            fail_count++;
            $error("step count above its maximum");
        end

endmodule

bind pet_top pet_checker u_checker (
    .clk             (clk),
    .reset           (reset),
    .test_mode       (test_mode),
    .display         (display),
    .enable_food     (enable_food),
    .enable_medicine (enable_medicine),
    .enable_light    (enable_light),
    .enable_presence (enable_presence),
    .step_count      (step_count)
);

// File: tb_pet.sv
`timescale 1ns/100ps

module tb_pet import pet_pkg::*; ();

    localparam int CLK_HALF    = 4;
    localparam int CLK_PERIOD  = 2 * CLK_HALF;
    localparam int DRIVE_DELAY = 1;
    localparam int POLL_STEP   = 2;      // Odd offsets keep polls off the edges
    localparam int SEED        = 35716;
    localparam int FIELDS      = 14;

    logic                clk;
    logic                reset;
    level_t              level_food;
    level_t              level_health;
    level_t              level_rest;
    level_t              level_mood;
    logic                care_food;
    logic                care_medicine;
    logic                care_light;
    logic                care_presence;
    logic                test_mode;
    logic                test_step;
    logic [3:0]          display;
    logic                enable_food;
    logic                enable_medicine;
    logic                enable_light;
    logic                enable_presence;
    logic [STATUS_W-1:0] status;

    int    edge_count   = 0;
    string cur_test     = "";
    int    test_errors  = 0;
    int    total_errors = 0;
    int    tests_run    = 0;
    int    tests_failed = 0;
    int    checks       = 0;
    int    steps        = 0;   // Test mode step pulses modulo 17
    bit    aborted      = 1'b0;

    pet_top uut (
        .clk             (clk),
        .reset           (reset),
        .level_food      (level_food),
        .level_health    (level_health),
        .level_rest      (level_rest),
        .level_mood      (level_mood),
        .care_food       (care_food),
        .care_medicine   (care_medicine),
        .care_light      (care_light),
        .care_presence   (care_presence),
        .test_mode       (test_mode),
        .test_step       (test_step),
        .display         (display),
        .enable_food     (enable_food),
        .enable_medicine (enable_medicine),
        .enable_light    (enable_light),
        .enable_presence (enable_presence),
        .status          (status)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_HALF) clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("ERROR: %s", reason);
        aborted = 1'b1;
    endtask

    // Starts and ends at the drive offset after an edge
    task automatic wait_edges(input int n);
        int target;
        int polls;
        target = edge_count + n;
        polls  = 0;
        while (!aborted && edge_count < target && polls < n * CLK_PERIOD) begin
            #(POLL_STEP);
            polls++;
        end
        if (!aborted && edge_count < target) begin
            abort_run($sformatf("clock stopped while waiting for %0d edges", n));
        end
    endtask

    task automatic check_value(input string what, input int expected, input int actual);
        checks++;
        assert (actual == expected) else begin
            $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_outputs(input int exp_disp, input int exp_en, input int exp_levels);
        check_value("display", exp_disp, 32'(display));
        check_value("enables", exp_en,
                    32'({enable_food, enable_medicine, enable_light, enable_presence}));
        check_value("status levels", exp_levels, 32'(status[15:0]));
        check_value("status display", exp_disp, 32'(status[19:16]));
        check_value("status steps", steps, 32'(status[27:20]));
    endtask

    task automatic close_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    initial begin
        int    fd;
        int    fields;
        int    idle;
        string line;
        string name;
        int    lf;
        int    lh;
        int    lr;
        int    lm;
        int    cf;
        int    cm;
        int    cl;
        int    cp;
        int    tm;
        int    pulse;
        int    edges;
        int    exp_disp;
        int    exp_en;
        int    exp_levels;

        reset         = 1'b0;
        level_food    = LEVEL_FULL;
        level_health  = LEVEL_FULL;
        level_rest    = LEVEL_FULL;
        level_mood    = LEVEL_FULL;
        care_food     = 1'b0;
        care_medicine = 1'b0;
        care_light    = 1'b0;
        care_presence = 1'b0;
        test_mode     = 1'b0;
        test_step     = 1'b0;
        void'($urandom(SEED));

        #(CLK_HALF + DRIVE_DELAY);   // Just past the first rising edge
        wait_edges(1);
        reset = 1'b1;

        cur_test = "reset";
        check_value("display", 0, 32'(display));
        check_value("enables", 'hF,
                    32'({enable_food, enable_medicine, enable_light, enable_presence}));
        check_value("status", 0, 32'(status));

        fd = $fopen("pet_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open pet_testdata.txt");
        end else begin
            while (!aborted && $fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %h",
                                     name, lf, lh, lr, lm, cf, cm, cl, cp, tm, pulse,
                                     edges, exp_disp, exp_en);
                    if (fields != FIELDS) begin
                        abort_run($sformatf("malformed data line: %s", line));
                    end else begin
                        if (name != cur_test) begin
                            close_test();
                            cur_test = name;
                        end
                        level_food    = lf[1:0];
                        level_health  = lh[1:0];
                        level_rest    = lr[1:0];
                        level_mood    = lm[1:0];
                        care_food     = cf[0];
                        care_medicine = cm[0];
                        care_light    = cl[0];
                        care_presence = cp[0];
                        test_mode     = tm[0];
                        test_step     = pulse[0];
                        if (pulse != 0) begin
                            wait_edges(1);   // Held high over one edge before the falling edge
                            test_step = 1'b0;
                            if (tm != 0) begin
                                steps = (steps + 1) % (int'(STEP_MAX) + 1);
                            end
                        end
                        wait_edges(edges);
                        exp_levels = (lr << 12) | (lh << 8) | (lm << 4) | lf;
                        if (!aborted) begin
                            check_outputs(exp_disp, exp_en, exp_levels);
                        end
                        idle = $urandom % 3;
                        wait_edges(idle);
                    end
                end
            end
            $fclose(fd);
        end
        close_test();
        total_errors += uut.u_checker.fail_count;

        $display("tests: %0d run, %0d failed; checks: %0d, errors: %0d",
                 tests_run, tests_failed, checks, total_errors);
        if (!aborted && total_errors == 0 && tests_run > 1) begin
            $display("RESULT: PASS");
        end else begin
            if (!aborted && tests_run < 2) begin
                $display("ERROR: no test vectors were read");
            end
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: pet_testdata.txt
# name food health rest mood | care food medicine light presence | test_mode step_pulse
# | edges to wait | expected display (dec) | expected enables food..presence (hex)
reset 3 3 3 3 0 0 0 0 0 0 3 0 F
priority 2 2 3 3 0 0 0 0 0 0 3 1 F
priority 2 3 3 3 1 0 0 0 0 0 3 3 0
priority 3 3 3 3 0 0 0 0 0 0 3 0 F
priority 3 3 2 3 0 0 0 0 0 0 3 7 F
priority 3 3 2 3 0 0 1 0 0 0 3 9 0
priority 3 3 3 3 0 0 0 0 0 0 3 0 F
food_chain 0 3 3 3 0 0 0 0 0 0 3 2 F
food_chain 0 3 3 3 1 0 0 0 0 0 3 3 0
food_chain 3 3 3 3 0 0 0 0 0 0 3 0 F
food_chain 2 3 3 3 1 0 0 0 0 0 3 3 0
food_chain 2 3 3 3 0 0 0 0 0 0 3 1 F
food_chain 2 3 3 3 1 0 0 0 0 0 3 3 0
food_chain 0 3 3 3 0 0 0 0 0 0 3 2 F
food_chain 3 3 3 3 1 0 0 0 0 0 3 3 0
food_chain 3 3 3 3 0 0 0 0 0 0 3 0 F
health_chain 3 0 3 3 0 0 0 0 0 0 3 5 F
health_chain 3 0 3 3 0 1 0 0 0 0 3 6 0
health_chain 3 2 3 3 0 0 0 0 0 0 3 4 F
health_chain 3 2 3 3 0 1 0 0 0 0 3 6 0
health_chain 3 3 3 3 0 0 0 0 0 0 3 0 F
rest_chain 3 3 0 3 0 0 0 0 0 0 3 8 F
rest_chain 3 3 0 3 0 0 1 0 0 0 3 9 0
rest_chain 3 3 2 3 0 0 0 0 0 0 3 7 F
rest_chain 3 3 2 3 0 0 1 0 0 0 3 9 0
rest_chain 3 3 3 3 0 0 0 0 0 0 3 0 F
mood_chain 3 3 3 0 0 0 0 0 0 0 3 11 F
mood_chain 3 3 3 0 0 0 0 1 0 0 3 12 0
mood_chain 3 3 3 2 0 0 0 0 0 0 3 10 F
mood_chain 3 3 3 2 0 0 0 1 0 0 3 12 0
mood_chain 3 3 3 3 0 0 0 0 0 0 3 0 F
test_mode 1 0 2 1 1 1 1 1 1 0 3 0 0
test_mode 1 0 2 1 1 1 1 1 1 1 3 1 0
test_mode 0 2 1 3 0 1 0 1 1 1 3 2 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 3 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 0 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 4 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 5 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 6 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 0 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 7 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 8 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 9 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 0 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 10 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 11 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 12 0
test_mode 3 3 3 3 0 0 0 0 1 1 3 0 0
test_exit 2 2 2 2 1 0 1 0 1 1 3 0 0
test_exit 3 3 3 3 0 0 0 0 1 1 3 1 0
test_exit 3 3 3 3 0 0 0 0 1 1 3 2 0
test_exit 3 3 3 3 0 0 0 0 0 0 3 0 F

// File: pet.f
pet_pkg.sv
pet_needs_if.sv
test_stepper.sv
pet_fsm.sv
pet_outputs.sv
pet_top.sv
pet_checker.sv
tb_pet.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pet
FILELIST  ?= pet.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= RESULT: PASS
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
